// File: rtl/openadc_pkg.sv
package openadc_pkg;

   localparam int ADC_WIDTH     = 12;
   localparam int GAIN_WIDTH    = 8;
   localparam int LED_SEL_WIDTH = 2;

   // register map, byte wide bus
   localparam logic [7:0] ADDR_GAIN       = 8'h00;
   localparam logic [7:0] ADDR_SETTINGS   = 8'h01;
   localparam logic [7:0] ADDR_STATUS     = 8'h02;
   localparam logic [7:0] ADDR_TRIG_LEVEL = 8'h03; // two bytes, low first

   // settings byte fields
   localparam int SET_ARM_BIT    = 0; // write-only strobe
   localparam int SET_SOURCE_BIT = 1; // 1 = adc pins, 0 = ramp
   localparam int SET_LED_LSB    = 2;

   // led modes
   localparam logic [LED_SEL_WIDTH-1:0] LED_STATUS    = 2'b00;
   localparam logic [LED_SEL_WIDTH-1:0] LED_HEARTBEAT = 2'b01;
   localparam logic [LED_SEL_WIDTH-1:0] LED_OFF_A     = 2'b10;
   localparam logic [LED_SEL_WIDTH-1:0] LED_OFF_B     = 2'b11;

   typedef logic [ADC_WIDTH-1:0] adc_sample_t;

   typedef struct packed {
      logic [GAIN_WIDTH-1:0]    gain;
      adc_sample_t              trig_level; // bit 11 picks above/below
      logic                     adc_source;
      logic [LED_SEL_WIDTH-1:0] led_select;
   } adc_cfg_t;

   typedef struct packed {
      logic armed;
      logic triggered;
   } trig_status_t;

endpackage

// File: rtl/openadc_regs.sv
`timescale 1ns/1ps

module openadc_regs #(
   parameter int BYTECNT_SIZE = 7
) (
   input  logic                         clk_usb,
   input  logic                         reset,
   input  logic [7:0]                   reg_address_i,
   input  logic [BYTECNT_SIZE-1:0]      reg_bytecnt_i,
   input  logic [7:0]                   reg_datai_i,
   input  logic                         reg_write_i,
   input  logic                         reg_read_i,
   output logic [7:0]                   reg_datao_o,
   input  openadc_pkg::trig_status_t    status_i,
   output openadc_pkg::adc_cfg_t        cfg_o,
   output logic                         arm_cmd_o
);

   localparam int LVL_HI_BITS = openadc_pkg::ADC_WIDTH - 8;

   openadc_pkg::adc_cfg_t cfg_r;
   logic [7:0]            read_data;
   logic                  byte0;
   logic                  byte1;

   assign byte0 = (reg_bytecnt_i == '0);
   assign byte1 = (reg_bytecnt_i == BYTECNT_SIZE'(1));

   // write decode
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         cfg_r     <= '0;
         arm_cmd_o <= 1'b0;
      end else begin
         arm_cmd_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               openadc_pkg::ADDR_GAIN: begin
                  if (byte0)
                     cfg_r.gain <= reg_datai_i[openadc_pkg::GAIN_WIDTH-1:0];
               end
               openadc_pkg::ADDR_TRIG_LEVEL: begin
                  if (byte0)
                     cfg_r.trig_level[7:0] <= reg_datai_i;
                  else if (byte1)
                     cfg_r.trig_level[openadc_pkg::ADC_WIDTH-1:8] <=
                        reg_datai_i[LVL_HI_BITS-1:0]; // upper nibble ignored
               end
               openadc_pkg::ADDR_SETTINGS: begin
                  if (byte0) begin
                     arm_cmd_o        <= reg_datai_i[openadc_pkg::SET_ARM_BIT];
                     cfg_r.adc_source <= reg_datai_i[openadc_pkg::SET_SOURCE_BIT];
                     cfg_r.led_select <= reg_datai_i[openadc_pkg::SET_LED_LSB +:
                                                     openadc_pkg::LED_SEL_WIDTH];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // read mux
   always_comb begin
      read_data = 8'h00;
      case (reg_address_i)
         openadc_pkg::ADDR_GAIN: begin
            if (byte0)
               read_data[openadc_pkg::GAIN_WIDTH-1:0] = cfg_r.gain;
         end
         openadc_pkg::ADDR_TRIG_LEVEL: begin
            if (byte0)
               read_data = cfg_r.trig_level[7:0];
            else if (byte1)
               read_data[LVL_HI_BITS-1:0] = cfg_r.trig_level[openadc_pkg::ADC_WIDTH-1:8];
         end
         openadc_pkg::ADDR_SETTINGS: begin
            if (byte0) begin
               read_data[openadc_pkg::SET_SOURCE_BIT] = cfg_r.adc_source;
               read_data[openadc_pkg::SET_LED_LSB +: openadc_pkg::LED_SEL_WIDTH] =
                  cfg_r.led_select;
            end
         end
         openadc_pkg::ADDR_STATUS: begin
            if (byte0) begin
               read_data[0] = status_i.armed;
               read_data[1] = status_i.triggered;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         reg_datao_o <= 8'h00;
      else if (reg_read_i)
         reg_datao_o <= read_data;
      else
         reg_datao_o <= 8'h00; // bus idles at zero
   end

   assign cfg_o = cfg_r;

endmodule

// File: rtl/adc_level_trigger.sv
`timescale 1ns/1ps

module adc_level_trigger (
   input  logic                         clk_usb,
   input  logic                         reset,
   input  openadc_pkg::adc_sample_t     adc_data_i,
   input  openadc_pkg::adc_cfg_t        cfg_i,
   input  logic                         arm_cmd_i,
   output logic                         trigger_adc_o,
   output openadc_pkg::trig_status_t    status_o
);

   openadc_pkg::adc_sample_t ramp;
   openadc_pkg::adc_sample_t sample_s1;
   openadc_pkg::adc_sample_t sample_s2;
   logic                     armed;
   logic                     armed_d;
   logic                     triggered;
   logic                     level_hit;
   logic                     fire;

   // test pattern, wraps freely
   always_ff @(posedge clk_usb) begin
      if (reset)
         ramp <= '0;
      else
         ramp <= ramp + 1'b1;
   end

   always_ff @(posedge clk_usb) begin
      sample_s1 <= cfg_i.adc_source ? adc_data_i : ramp;
      sample_s2 <= sample_s1;
   end

   // msb of the level selects the direction of the test
   assign level_hit = cfg_i.trig_level[openadc_pkg::ADC_WIDTH-1] ?
                      (sample_s2 > cfg_i.trig_level) :
                      (sample_s2 < cfg_i.trig_level);

   // armed_d keeps samples from before the arm out of the compare
   assign fire = armed && armed_d && level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed         <= 1'b0;
         armed_d       <= 1'b0;
         triggered     <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         armed_d       <= armed;
         trigger_adc_o <= fire;
         if (fire) begin
            armed     <= 1'b0; // single shot
            triggered <= 1'b1;
         end else if (arm_cmd_i && !armed) begin
            armed     <= 1'b1;
            triggered <= 1'b0;
         end
      end
   end

   assign status_o.armed     = armed;
   assign status_o.triggered = triggered;

endmodule

// File: rtl/board_outputs.sv
`timescale 1ns/1ps

module board_outputs #(
   parameter int HB_WIDTH = 26
) (
   input  logic                         clk_usb,
   input  logic                         reset,
   input  openadc_pkg::adc_cfg_t        cfg_i,
   input  openadc_pkg::trig_status_t    status_i,
   output logic                         freq_measure_o,
   output logic                         led_armed_o,
   output logic                         led_capture_o,
   output logic                         amp_gain_o
);

   logic [HB_WIDTH-1:0]               hb_timer;
   logic                              hb_tap_r;
   logic [openadc_pkg::GAIN_WIDTH:0]  pwm_acc;

   // heartbeat and rising edge of the measure tap
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         hb_timer       <= '0;
         hb_tap_r       <= 1'b0;
         freq_measure_o <= 1'b0;
      end else begin
         hb_timer       <= hb_timer + 1'b1;
         hb_tap_r       <= hb_timer[HB_WIDTH-4];
         freq_measure_o <= hb_timer[HB_WIDTH-4] && !hb_tap_r;
      end
   end

   always_comb begin
      case (cfg_i.led_select)
         openadc_pkg::LED_STATUS: begin
            led_armed_o   = status_i.armed;
            led_capture_o = status_i.triggered;
         end
         openadc_pkg::LED_HEARTBEAT: begin
            led_armed_o   = hb_timer[HB_WIDTH-2];
            led_capture_o = !hb_timer[HB_WIDTH-2];
         end
         openadc_pkg::LED_OFF_A,
         openadc_pkg::LED_OFF_B: begin
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
         default: begin
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
      endcase
   end

   // carry out is high gain times per 256
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[openadc_pkg::GAIN_WIDTH-1:0]} + cfg_i.gain;
   end

   assign amp_gain_o = pwm_acc[openadc_pkg::GAIN_WIDTH];

endmodule

// File: rtl/openadc_top.sv
`timescale 1ns/1ps

module openadc_top #(
   parameter int BYTECNT_SIZE = 7,
   parameter int HB_WIDTH     = 26
) (
   input  logic                         clk_usb,
   input  logic                         reset,

   // register bus
   input  logic [7:0]                   reg_address_i,
   input  logic [BYTECNT_SIZE-1:0]      reg_bytecnt_i,
   input  logic [7:0]                   reg_datai_i,
   input  logic                         reg_write_i,
   input  logic                         reg_read_i,
   output logic [7:0]                   reg_datao_o,

   input  openadc_pkg::adc_sample_t     adc_data_i,
   output logic                         trigger_adc_o,
   output logic                         armed_o,
   output logic                         freq_measure_o,
   output logic                         led_armed_o,
   output logic                         led_capture_o,
   output logic                         amp_gain_o
);

   openadc_pkg::adc_cfg_t     cfg;
   openadc_pkg::trig_status_t status;
   logic                      arm_cmd;

   openadc_regs #(
      .BYTECNT_SIZE   (BYTECNT_SIZE)
   ) u_regs (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_bytecnt_i  (reg_bytecnt_i),
      .reg_datai_i    (reg_datai_i),
      .reg_write_i    (reg_write_i),
      .reg_read_i     (reg_read_i),
      .reg_datao_o    (reg_datao_o),
      .status_i       (status),
      .cfg_o          (cfg),
      .arm_cmd_o      (arm_cmd)
   );

   adc_level_trigger u_trigger (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .cfg_i          (cfg),
      .arm_cmd_i      (arm_cmd),
      .trigger_adc_o  (trigger_adc_o),
      .status_o       (status)
   );

   board_outputs #(
      .HB_WIDTH       (HB_WIDTH)
   ) u_outputs (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .cfg_i          (cfg),
      .status_i       (status),
      .freq_measure_o (freq_measure_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o),
      .amp_gain_o     (amp_gain_o)
   );

   assign armed_o = status.armed;

endmodule

// File: test/openadc_properties.sv
`timescale 1ns/1ps

module openadc_properties (
   input logic clk_usb,
   input logic reset,
   input logic trigger_adc_o,
   input logic armed_o,
   input logic freq_measure_o
);

   // one pulse per arm, never stretched
   trig_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
                                    trigger_adc_o |=> !trigger_adc_o)
      else $error("trigger_adc_o high for two cycles");

   trig_needs_arm: assert property (@(posedge clk_usb) disable iff (reset)
                                    trigger_adc_o |-> $past(armed_o))
      else $error("trigger_adc_o without armed_o in the previous cycle");

   freq_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
                                    freq_measure_o |=> !freq_measure_o)
      else $error("freq_measure_o high for two cycles");

endmodule

bind openadc_top openadc_properties u_properties (
   .clk_usb        (clk_usb),
   .reset          (reset),
   .trigger_adc_o  (trigger_adc_o),
   .armed_o        (armed_o),
   .freq_measure_o (freq_measure_o)
);

// File: test/tb_openadc.sv
`timescale 1ns/1ps

module tb_openadc;

   localparam int HB_WIDTH     = 8;
   localparam int BYTECNT_SIZE = 7;
   localparam int MAX_CYCLES   = 20000; // tests need about 11k cycles

   logic                      clk_usb = 1'b0;
   logic                      reset;
   logic [7:0]                reg_address_i;
   logic [BYTECNT_SIZE-1:0]   reg_bytecnt_i;
   logic [7:0]                reg_datai_i;
   logic                      reg_write_i;
   logic                      reg_read_i;
   logic [7:0]                reg_datao_o;
   openadc_pkg::adc_sample_t  adc_data_i;
   logic                      trigger_adc_o, armed_o, freq_measure_o;
   logic                      led_armed_o, led_capture_o, amp_gain_o;

   openadc_pkg::adc_cfg_t     cfg_m; // reference copy of the registers
   openadc_pkg::trig_status_t st_m;
   int                        cycles = 0;
   int                        errors = 0;
   int                        test_errors = 0;
   int                        tests_run = 0;
   int                        tests_passed = 0;

   openadc_top #(.BYTECNT_SIZE(BYTECNT_SIZE), .HB_WIDTH(HB_WIDTH)) dut0 (.*);

   always #5 clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic flag_error(input string msg);
      errors++;
      test_errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0)
         tests_passed++;
      $display("test %0d (%s): %s", tests_run, name, test_errors == 0 ? "passed" : "failed");
      test_errors = 0;
   endtask

   task automatic apply_reset();
      @(posedge clk_usb);
      reset <= 1'b1;
      repeat (3) @(posedge clk_usb);
      reset <= 1'b0;
      cfg_m = '0;
      st_m  = '0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input int bc, input logic [7:0] data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= BYTECNT_SIZE'(bc);
      reg_datai_i   <= data;
      reg_write_i   <= 1'b1;
      @(posedge clk_usb);
      reg_write_i   <= 1'b0;
   endtask

   task automatic check_byte(input logic [7:0] addr, input int bc, input logic [7:0] exp,
                             input string what);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= BYTECNT_SIZE'(bc);
      reg_read_i    <= 1'b1;
      @(posedge clk_usb);
      reg_read_i    <= 1'b0;
      @(negedge clk_usb); // read data valid for this cycle
      if (reg_datao_o !== exp)
         flag_error($sformatf("%s read %h, expected %h", what, reg_datao_o, exp));
   endtask

   task automatic set_level(input openadc_pkg::adc_sample_t lvl);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL, 0, lvl[7:0]);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL, 1, {4'h0, lvl[11:8]});
      cfg_m.trig_level = lvl;
   endtask

   task automatic set_settings(input logic arm, input logic src, input logic [1:0] led);
      write_reg(openadc_pkg::ADDR_SETTINGS, 0, {4'h0, led, src, arm});
      cfg_m.adc_source = src;
      cfg_m.led_select = led;
      if (arm && !st_m.armed)
         st_m = '{1'b1, 1'b0};
   endtask

   task automatic check_status();
      check_byte(openadc_pkg::ADDR_STATUS, 0, {6'h0, st_m.triggered, st_m.armed}, "status");
      if (armed_o !== st_m.armed)
         flag_error($sformatf("armed_o %b, expected %b", armed_o, st_m.armed));
   endtask

   task automatic check_leds(input string what);
      logic exp_a;
      logic exp_c;
      exp_a = (cfg_m.led_select == openadc_pkg::LED_STATUS) ? st_m.armed : 1'b0;
      exp_c = (cfg_m.led_select == openadc_pkg::LED_STATUS) ? st_m.triggered : 1'b0;
      if (led_armed_o !== exp_a || led_capture_o !== exp_c)
         flag_error($sformatf("%s: leds %b%b, expected %b%b", what, led_armed_o,
                              led_capture_o, exp_a, exp_c));
   endtask

   // level with bit 11 set fires above, otherwise below
   function automatic openadc_pkg::adc_sample_t pick_level(input bit above);
      int unsigned l;
      l = above ? 32'h800 + $urandom % 32'h7ff : 1 + $urandom % 32'h7ff;
      return l[11:0];
   endfunction

   function automatic openadc_pkg::adc_sample_t pick_sample(input openadc_pkg::adc_sample_t lvl,
                                                            input bit pass);
      int unsigned l;
      int unsigned s;
      l = lvl;
      if (lvl[11])
         s = pass ? l + 1 + $urandom % (4095 - l) : $urandom % (l + 1);
      else
         s = pass ? $urandom % l : l + $urandom % (4096 - l);
      return s[11:0];
   endfunction

   task automatic drive_sample(input openadc_pkg::adc_sample_t s);
      @(posedge clk_usb);
      adc_data_i <= s;
   endtask

   task automatic count_pulses(input int ncyc, input bit drive, input bit pass,
                               input openadc_pkg::adc_sample_t lvl, output int cnt);
      cnt = 0;
      repeat (ncyc) begin
         if (drive)
            drive_sample(pick_sample(lvl, pass));
         else
            @(posedge clk_usb);
         @(negedge clk_usb);
         if (trigger_adc_o)
            cnt++;
      end
   endtask

   initial begin
      openadc_pkg::adc_sample_t lvl;
      logic [7:0]               g, lo, hi, s;
      logic                     prev;
      int                       n, last;
      void'($urandom(45));
      reset         = 1'b1;
      reg_address_i = '0;
      reg_bytecnt_i = '0;
      reg_datai_i   = '0;
      reg_write_i   = 1'b0;
      reg_read_i    = 1'b0;
      adc_data_i    = '0;

      apply_reset();
      for (int i = 0; i < 8; i++) begin
         g  = 8'($urandom);
         lo = 8'($urandom);
         hi = 8'($urandom);
         s  = 8'($urandom);
         write_reg(openadc_pkg::ADDR_GAIN, 0, g);
         write_reg(openadc_pkg::ADDR_TRIG_LEVEL, 0, lo);
         write_reg(openadc_pkg::ADDR_TRIG_LEVEL, 1, hi);
         write_reg(openadc_pkg::ADDR_SETTINGS, 0, s);
         cfg_m = '{g, {hi[3:0], lo}, s[1], s[3:2]};
         check_byte(openadc_pkg::ADDR_GAIN, 0, cfg_m.gain, "gain");
         check_byte(openadc_pkg::ADDR_TRIG_LEVEL, 0, cfg_m.trig_level[7:0], "level byte 0");
         check_byte(openadc_pkg::ADDR_TRIG_LEVEL, 1, {4'h0, cfg_m.trig_level[11:8]},
                    "level byte 1");
         check_byte(openadc_pkg::ADDR_SETTINGS, 0,
                    {4'h0, cfg_m.led_select, cfg_m.adc_source, 1'b0}, "settings");
         check_byte(8'(4 + $urandom % 252), 0, 8'h00, "unknown address");
      end
      end_test("register readback");

      apply_reset();
      for (int i = 0; i < 20; i++) begin
         g = 8'($urandom);
         write_reg(openadc_pkg::ADDR_GAIN, 0, g);
         cfg_m.gain = g;
         repeat (2) @(negedge clk_usb); // new gain in the accumulator
         n = 0;
         repeat (256) begin
            @(negedge clk_usb);
            if (amp_gain_o)
               n++;
         end
         if (n != cfg_m.gain)
            flag_error($sformatf("gain %0d gave %0d high cycles in 256", cfg_m.gain, n));
      end
      end_test("gain pwm");

      for (int pol = 0; pol < 2; pol++) begin
         apply_reset();
         lvl = pick_level(pol == 1);
         drive_sample(pick_sample(lvl, 1'b0));
         set_level(lvl);
         set_settings(1'b1, 1'b1, openadc_pkg::LED_STATUS);
         count_pulses(30, 1'b1, 1'b0, lvl, n);
         if (n != 0)
            flag_error($sformatf("%0d pulses on failing samples, level %h", n, lvl));
         drive_sample(pick_sample(lvl, 1'b1)); // edge E is the next one
         for (int k = 1; k <= 5; k++) begin
            drive_sample(pick_sample(lvl, 1'b0));
            @(negedge clk_usb);
            if (trigger_adc_o !== (k == 3))
               flag_error($sformatf("trigger_adc_o %b at %0d cycles after passing sample",
                                    trigger_adc_o, k));
         end
      end
      end_test("trigger latency");

      apply_reset();
      lvl = pick_level(($urandom % 2) == 1);
      drive_sample(pick_sample(lvl, 1'b0));
      set_level(lvl);
      set_settings(1'b1, 1'b1, openadc_pkg::LED_STATUS);
      count_pulses(5, 1'b1, 1'b0, lvl, n);
      if (n != 0)
         flag_error($sformatf("%0d pulses on failing samples", n));
      drive_sample(pick_sample(lvl, 1'b1));
      count_pulses(6, 1'b1, 1'b0, lvl, n);
      if (n != 1)
         flag_error($sformatf("%0d pulses for one passing sample", n));
      st_m = '{1'b0, 1'b1};
      check_status();
      count_pulses(20, 1'b1, 1'b1, lvl, n);
      if (n != 0)
         flag_error("trigger pulse while not armed");
      drive_sample(pick_sample(lvl, 1'b0));
      set_settings(1'b1, 1'b1, openadc_pkg::LED_STATUS);
      check_status();
      count_pulses(20, 1'b1, 1'b1, lvl, n);
      if (n != 1)
         flag_error($sformatf("%0d pulses after re-arm", n));
      st_m = '{1'b0, 1'b1};
      check_status();
      end_test("single shot");

      apply_reset();
      set_level(12'h800);
      set_settings(1'b1, 1'b0, openadc_pkg::LED_STATUS);
      count_pulses(4200, 1'b0, 1'b0, 12'h800, n);
      if (n != 1)
         flag_error($sformatf("%0d pulses on the ramp, expected 1", n));
      end_test("ramp source");

      apply_reset();
      last = -1;
      for (int k = 0; k < 200; k++) begin
         @(negedge clk_usb);
         if (freq_measure_o) begin
            if (last >= 0 && k - last != 32)
               flag_error($sformatf("freq_measure_o period %0d", k - last));
            last = k;
         end
      end
      if (last < 0)
         flag_error("freq_measure_o never pulsed");
      drive_sample(12'h000);
      set_level(12'h800);
      set_settings(1'b0, 1'b1, openadc_pkg::LED_STATUS);
      @(negedge clk_usb);
      check_leds("status idle");
      set_settings(1'b1, 1'b1, openadc_pkg::LED_STATUS);
      repeat (2) @(negedge clk_usb);
      check_leds("status armed");
      drive_sample(12'hfff);
      repeat (5) @(negedge clk_usb);
      st_m = '{1'b0, 1'b1};
      check_leds("status triggered");
      set_settings(1'b0, 1'b1, openadc_pkg::LED_HEARTBEAT);
      last = -1;
      prev = 1'b0;
      for (int k = 0; k < 300; k++) begin
         @(negedge clk_usb);
         if (led_armed_o === led_capture_o)
            flag_error("heartbeat leds not opposite");
         if (k > 0 && led_armed_o !== prev) begin
            if (last >= 0 && k - last != 64)
               flag_error($sformatf("heartbeat half period %0d", k - last));
            last = k;
         end
         prev = led_armed_o;
      end
      if (last < 0)
         flag_error("heartbeat led never toggled");
      for (int m = 0; m < 2; m++) begin
         set_settings(1'b0, 1'b1, m == 0 ? openadc_pkg::LED_OFF_A : openadc_pkg::LED_OFF_B);
         repeat (10) begin
            @(negedge clk_usb);
            check_leds("off mode");
         end
      end
      end_test("board outputs");

      $display("%0d of %0d tests passed, %0d checks failed", tests_passed, tests_run, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: files.f
rtl/openadc_pkg.sv
rtl/openadc_regs.sv
rtl/adc_level_trigger.sv
rtl/board_outputs.sv
rtl/openadc_top.sv
test/openadc_properties.sv
test/tb_openadc.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_openadc
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
